// File: verilog/retire_pkg.sv
/* shared widths, functional-unit and operation encodings,
   supported CSR addresses and exception causes for the retire subsystem */
`default_nettype none

package retire_pkg;

  // --------------------
  // widths
  // --------------------
  localparam int XLEN       = 32;
  localparam int REG_ADDR_W = 5;
  localparam int CSR_ADDR_W = 12;
  // also the width of the fp flag vector carried in ex_cause
  localparam int CAUSE_W    = 5;

  // queue sizing, depth kept a power of two so pointers wrap on their own
  localparam int QUEUE_DEPTH = 4;
  localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
  localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

  // --------------------
  // encodings
  // --------------------
  // functional unit that produced the entry
  typedef enum logic [2:0] {
    FU_ALU   = 3'd0,
    FU_LOAD  = 3'd1,
    FU_STORE = 3'd2,
    FU_CSR   = 3'd3,
    FU_FPU   = 3'd4,
    FU_FENCE = 3'd5
  } fu_t;

  // operation, only csr and fence entries look at it
  typedef enum logic [1:0] {
    OP_NONE  = 2'd0,
    OP_CSRRW = 2'd1,
    OP_CSRRS = 2'd2,
    OP_FENCE = 2'd3
  } op_t;

  // csr map
  localparam logic [CSR_ADDR_W-1:0] CSR_FFLAGS   = 12'h001;
  localparam logic [CSR_ADDR_W-1:0] CSR_MSCRATCH = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] CSR_MEPC     = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] CSR_MCAUSE   = 12'h342;

  // exception causes raised inside the subsystem
  localparam logic [CAUSE_W-1:0] CAUSE_ILLEGAL_INSTR = 5'd2;

endpackage

`default_nettype wire

// File: verilog/instr_queue.sv
/* in-order instruction queue with a four-phase req/ack intake,
   presents the oldest entry to the commit stage */
`timescale 1ns/1ps
`default_nettype none

module instr_queue import retire_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  in_req_i,
  input  logic [XLEN-1:0]       in_pc_i,
  input  fu_t                   in_fu_i,
  input  op_t                   in_op_i,
  input  logic [REG_ADDR_W-1:0] in_rd_i,
  input  logic [XLEN-1:0]       in_result_i,
  input  logic [CSR_ADDR_W-1:0] in_csr_addr_i,
  input  logic                  in_ex_valid_i,
  input  logic [CAUSE_W-1:0]    in_ex_cause_i,
  input  logic                  commit_ack_i,
  input  logic                  flush_i,
  output logic                  in_ack_o,
  output logic                  head_valid_o,
  output logic [XLEN-1:0]       head_pc_o,
  output fu_t                   head_fu_o,
  output op_t                   head_op_o,
  output logic [REG_ADDR_W-1:0] head_rd_o,
  output logic [XLEN-1:0]       head_result_o,
  output logic [CSR_ADDR_W-1:0] head_csr_addr_o,
  output logic                  head_ex_valid_o,
  output logic [CAUSE_W-1:0]    head_ex_cause_o
);

  typedef enum logic {IN_IDLE, IN_ACK} in_state_t;

  in_state_t              in_state_q;
  logic [QUEUE_PTR_W-1:0] rd_ptr_q;
  logic [QUEUE_PTR_W-1:0] wr_ptr_q;
  logic [QUEUE_CNT_W-1:0] count_q;
  logic                   push;
  logic                   pop;

  // entry storage, one array per field
  logic [XLEN-1:0]       pc_mem     [QUEUE_DEPTH];
  fu_t                   fu_mem     [QUEUE_DEPTH];
  op_t                   op_mem     [QUEUE_DEPTH];
  logic [REG_ADDR_W-1:0] rd_mem     [QUEUE_DEPTH];
  logic [XLEN-1:0]       result_mem [QUEUE_DEPTH];
  logic [CSR_ADDR_W-1:0] csr_mem    [QUEUE_DEPTH];
  logic                  exv_mem    [QUEUE_DEPTH];
  logic [CAUSE_W-1:0]    exc_mem    [QUEUE_DEPTH];

  // --------------------
  // intake handshake
  // --------------------
  // one write per handshake, a flush cycle defers the capture by one cycle
  assign push     = (in_state_q == IN_IDLE) && in_req_i && !flush_i &&
                    (count_q != QUEUE_CNT_W'(QUEUE_DEPTH));
  assign pop      = commit_ack_i;
  assign in_ack_o = (in_state_q == IN_ACK);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      in_state_q <= IN_IDLE;
    end else if (push) begin
      in_state_q <= IN_ACK;
    end else if (in_ack_o && !in_req_i) begin
      // producer released, ack drops and the next request may start
      in_state_q <= IN_IDLE;
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      pc_mem[wr_ptr_q]     <= in_pc_i;
      fu_mem[wr_ptr_q]     <= in_fu_i;
      op_mem[wr_ptr_q]     <= in_op_i;
      rd_mem[wr_ptr_q]     <= in_rd_i;
      result_mem[wr_ptr_q] <= in_result_i;
      csr_mem[wr_ptr_q]    <= in_csr_addr_i;
      exv_mem[wr_ptr_q]    <= in_ex_valid_i;
      exc_mem[wr_ptr_q]    <= in_ex_cause_i;
    end
  end

  // --------------------
  // pointers and count
  // --------------------
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      // exception taken, drop everything still waiting
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  // head view for the commit stage
  assign head_valid_o    = (count_q != '0);
  assign head_pc_o       = pc_mem[rd_ptr_q];
  assign head_fu_o       = fu_mem[rd_ptr_q];
  assign head_op_o       = op_mem[rd_ptr_q];
  assign head_rd_o       = rd_mem[rd_ptr_q];
  assign head_result_o   = result_mem[rd_ptr_q];
  assign head_csr_addr_o = csr_mem[rd_ptr_q];
  assign head_ex_valid_o = exv_mem[rd_ptr_q];
  assign head_ex_cause_o = exc_mem[rd_ptr_q];

  // commit must only acknowledge an entry that exists
  assert property (@(posedge clk_i) disable iff (!rst_n_i) commit_ack_i |-> count_q != '0)
    else $error("instr_queue: pop while empty");

  // ack only answers a live request
  assert property (@(posedge clk_i) disable iff (!rst_n_i) $rose(in_ack_o) |-> in_req_i)
    else $error("instr_queue: in_ack_o rose without in_req_i");

endmodule

`default_nettype wire

// File: verilog/commit_stage.sv
/* single-port commit stage, retires the queue head into the register write port,
   store port and CSR file, and selects and reports exceptions */
`timescale 1ns/1ps
`default_nettype none

module commit_stage import retire_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  halt_i,
  input  logic                  head_valid_i,
  input  logic [XLEN-1:0]       head_pc_i,
  input  fu_t                   head_fu_i,
  input  op_t                   head_op_i,
  input  logic [REG_ADDR_W-1:0] head_rd_i,
  input  logic [XLEN-1:0]       head_result_i,
  input  logic [CSR_ADDR_W-1:0] head_csr_addr_i,
  input  logic                  head_ex_valid_i,
  input  logic [CAUSE_W-1:0]    head_ex_cause_i,
  input  logic [XLEN-1:0]       csr_rdata_i,
  input  logic                  csr_exception_i,
  input  logic                  st_ready_i,
  input  logic                  no_st_pending_i,
  output logic                  commit_ack_o,
  output logic                  flush_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output op_t                   csr_op_o,
  output logic [CSR_ADDR_W-1:0] csr_addr_o,
  output logic [XLEN-1:0]       csr_wdata_o,
  output logic                  csr_commit_o,
  output logic                  fflags_we_o,
  output logic [CAUSE_W-1:0]    fflags_wdata_o,
  output logic                  trap_we_o,
  output logic [XLEN-1:0]       trap_pc_o,
  output logic [CAUSE_W-1:0]    trap_cause_o,
  output logic                  commit_st_o,
  output logic [XLEN-1:0]       st_data_o,
  output logic                  fence_o,
  output logic                  exc_valid_o,
  output logic [CAUSE_W-1:0]    exc_cause_o,
  output logic [XLEN-1:0]       exc_tval_o
);

  logic is_csr;
  logic rd_nz;
  logic retire_ok;

  assign is_csr = (head_fu_i == FU_CSR);
  // x0 is hardwired, never written
  assign rd_nz  = (head_rd_i != '0);

  // csr access is presented straight from the head, the csr file answers in the same cycle
  assign csr_op_o    = (head_valid_i && is_csr) ? head_op_i : OP_NONE;
  assign csr_addr_o  = head_csr_addr_i;
  assign csr_wdata_o = head_result_i;

  // payload paths that need no decision
  assign rf_waddr_o     = head_rd_i;
  assign st_data_o      = head_result_i;
  assign fflags_wdata_o = head_ex_cause_i;

  // --------------------
  // exception selection
  // --------------------
  // an exception already carried by the entry wins over the csr one
  // halt masks every exception
  assign exc_valid_o = head_valid_i && !halt_i && (head_ex_valid_i || (is_csr && csr_exception_i));
  assign exc_cause_o = head_ex_valid_i ? head_ex_cause_i : CAUSE_ILLEGAL_INSTR;
  assign exc_tval_o  = head_pc_i;

  // trap record into mepc/mcause, then drop the queue instead of popping
  assign trap_we_o    = exc_valid_o;
  assign trap_pc_o    = head_pc_i;
  assign trap_cause_o = exc_cause_o;
  assign flush_o      = exc_valid_o;

  assign retire_ok = head_valid_i && !halt_i && !exc_valid_o;

  // --------------------
  // retire decision
  // --------------------
  always_comb begin
    commit_ack_o = 1'b0;
    rf_we_o      = 1'b0;
    rf_wdata_o   = head_result_i;
    csr_commit_o = 1'b0;
    fflags_we_o  = 1'b0;
    commit_st_o  = 1'b0;
    fence_o      = 1'b0;
    if (retire_ok) begin
      case (head_fu_i)
        FU_ALU, FU_LOAD: begin
          commit_ack_o = 1'b1;
          rf_we_o      = rd_nz;
        end
        FU_FPU: begin
          // accrue the flags along with the result write
          commit_ack_o = 1'b1;
          rf_we_o      = rd_nz;
          fflags_we_o  = 1'b1;
        end
        FU_STORE: begin
          // stall the head while the store buffer is still busy
          commit_ack_o = st_ready_i;
          commit_st_o  = st_ready_i;
        end
        FU_CSR: begin
          // rd gets the old csr value
          commit_ack_o = 1'b1;
          csr_commit_o = 1'b1;
          rf_we_o      = rd_nz;
          rf_wdata_o   = csr_rdata_i;
        end
        FU_FENCE: begin
          // drain outstanding stores first
          commit_ack_o = no_st_pending_i;
          fence_o      = no_st_pending_i;
        end
        default: begin
          commit_ack_o = 1'b0;
        end
      endcase
    end
  end

  // a head is either popped or flushed, never both
  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(commit_ack_o && flush_o))
    else $error("commit_stage: commit_ack_o and flush_o together");

endmodule

`default_nettype wire

// File: verilog/csr_file.sv
/* fflags, mscratch, mepc and mcause registers with combinational read,
   illegal-address detection, flag accrual and trap recording */
`timescale 1ns/1ps
`default_nettype none

module csr_file import retire_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  op_t                   csr_op_i,
  input  logic [CSR_ADDR_W-1:0] csr_addr_i,
  input  logic [XLEN-1:0]       csr_wdata_i,
  input  logic                  csr_commit_i,
  input  logic                  fflags_we_i,
  input  logic [CAUSE_W-1:0]    fflags_wdata_i,
  input  logic                  trap_we_i,
  input  logic [XLEN-1:0]       trap_pc_i,
  input  logic [CAUSE_W-1:0]    trap_cause_i,
  output logic [XLEN-1:0]       csr_rdata_o,
  output logic                  csr_exception_o
);

  logic [CAUSE_W-1:0] fflags_q;
  logic [XLEN-1:0]    mscratch_q;
  logic [XLEN-1:0]    mepc_q;
  logic [CAUSE_W-1:0] mcause_q;
  logic               addr_ok;
  logic [XLEN-1:0]    new_val;

  // read mux, unknown addresses read zero
  always_comb begin
    addr_ok     = 1'b1;
    csr_rdata_o = '0;
    case (csr_addr_i)
      CSR_FFLAGS:   csr_rdata_o = XLEN'(fflags_q);
      CSR_MSCRATCH: csr_rdata_o = mscratch_q;
      CSR_MEPC:     csr_rdata_o = mepc_q;
      CSR_MCAUSE:   csr_rdata_o = XLEN'(mcause_q);
      default:      addr_ok     = 1'b0;
    endcase
  end

  // only an actual access can fault
  assign csr_exception_o = (csr_op_i != OP_NONE) && !addr_ok;

  // csrrw replaces, csrrs sets bits
  assign new_val = (csr_op_i == OP_CSRRS) ? (csr_rdata_o | csr_wdata_i) : csr_wdata_i;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fflags_q   <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
    end else begin
      if (fflags_we_i) begin
        // fp flags are sticky
        fflags_q <= fflags_q | fflags_wdata_i;
      end else if (csr_commit_i && csr_addr_i == CSR_FFLAGS) begin
        fflags_q <= new_val[CAUSE_W-1:0];
      end
      if (csr_commit_i && csr_addr_i == CSR_MSCRATCH) begin
        mscratch_q <= new_val;
      end
      if (trap_we_i) begin
        mepc_q   <= trap_pc_i;
        mcause_q <= trap_cause_i;
      end else if (csr_commit_i && csr_addr_i == CSR_MEPC) begin
        mepc_q <= new_val;
      end else if (csr_commit_i && csr_addr_i == CSR_MCAUSE) begin
        mcause_q <= new_val[CAUSE_W-1:0];
      end
    end
  end

endmodule

`default_nettype wire

// File: verilog/store_commit_port.sv
/* one-entry store buffer driving a four-phase req/ack master to memory */
`timescale 1ns/1ps
`default_nettype none

module store_commit_port import retire_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  logic            commit_st_i,
  input  logic [XLEN-1:0] st_data_i,
  input  logic            st_ack_i,
  output logic            st_ready_o,
  output logic            no_st_pending_o,
  output logic            st_req_o,
  output logic [XLEN-1:0] st_data_o
);

  typedef enum logic [1:0] {ST_IDLE, ST_REQ, ST_RELEASE} st_state_t;

  st_state_t       state_q;
  logic [XLEN-1:0] data_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= ST_IDLE;
    end else begin
      case (state_q)
        ST_IDLE: if (commit_st_i) state_q <= ST_REQ;
        // memory took the data
        ST_REQ: if (st_ack_i) state_q <= ST_RELEASE;
        // wait for ack low before the next store
        ST_RELEASE: if (!st_ack_i) state_q <= ST_IDLE;
        default: state_q <= ST_IDLE;
      endcase
    end
  end

  // buffered store data, held for the whole handshake
  always_ff @(posedge clk_i) begin
    if (commit_st_i) begin
      data_q <= st_data_i;
    end
  end

  assign st_req_o        = (state_q == ST_REQ);
  assign st_data_o       = data_q;
  assign st_ready_o      = (state_q == ST_IDLE);
  assign no_st_pending_o = (state_q == ST_IDLE);

  // commit stage must respect st_ready_o
  assert property (@(posedge clk_i) disable iff (!rst_n_i) commit_st_i |-> state_q == ST_IDLE)
    else $error("store_commit_port: store committed while busy");

endmodule

`default_nettype wire

// File: verilog/retire_unit.sv
/* retire subsystem top, instruction queue, commit stage, CSR file and store port */
`timescale 1ns/1ps
`default_nettype none

module retire_unit import retire_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic                  halt_i,
  input  logic                  in_req_i,
  input  logic [XLEN-1:0]       in_pc_i,
  input  fu_t                   in_fu_i,
  input  op_t                   in_op_i,
  input  logic [REG_ADDR_W-1:0] in_rd_i,
  input  logic [XLEN-1:0]       in_result_i,
  input  logic [CSR_ADDR_W-1:0] in_csr_addr_i,
  input  logic                  in_ex_valid_i,
  input  logic [CAUSE_W-1:0]    in_ex_cause_i,
  input  logic                  st_ack_i,
  output logic                  in_ack_o,
  output logic                  rf_we_o,
  output logic [REG_ADDR_W-1:0] rf_waddr_o,
  output logic [XLEN-1:0]       rf_wdata_o,
  output logic                  fence_o,
  output logic                  exc_valid_o,
  output logic [CAUSE_W-1:0]    exc_cause_o,
  output logic [XLEN-1:0]       exc_tval_o,
  output logic                  st_req_o,
  output logic [XLEN-1:0]       st_data_o
);

  // --------------------
  // queue head
  // --------------------
  logic                  head_valid;
  logic [XLEN-1:0]       head_pc;
  fu_t                   head_fu;
  op_t                   head_op;
  logic [REG_ADDR_W-1:0] head_rd;
  logic [XLEN-1:0]       head_result;
  logic [CSR_ADDR_W-1:0] head_csr_addr;
  logic                  head_ex_valid;
  logic [CAUSE_W-1:0]    head_ex_cause;
  logic                  commit_ack;
  logic                  flush;

  // csr side
  op_t                   csr_op;
  logic [CSR_ADDR_W-1:0] csr_addr;
  logic [XLEN-1:0]       csr_wdata;
  logic                  csr_commit;
  logic [XLEN-1:0]       csr_rdata;
  logic                  csr_exception;
  logic                  fflags_we;
  logic [CAUSE_W-1:0]    fflags_wdata;
  logic                  trap_we;
  logic [XLEN-1:0]       trap_pc;
  logic [CAUSE_W-1:0]    trap_cause;

  // store side
  logic                  commit_st;
  logic [XLEN-1:0]       commit_st_data;
  logic                  st_ready;
  logic                  no_st_pending;

  instr_queue u_instr_queue (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .in_req_i        (in_req_i),
    .in_pc_i         (in_pc_i),
    .in_fu_i         (in_fu_i),
    .in_op_i         (in_op_i),
    .in_rd_i         (in_rd_i),
    .in_result_i     (in_result_i),
    .in_csr_addr_i   (in_csr_addr_i),
    .in_ex_valid_i   (in_ex_valid_i),
    .in_ex_cause_i   (in_ex_cause_i),
    .commit_ack_i    (commit_ack),
    .flush_i         (flush),
    .in_ack_o        (in_ack_o),
    .head_valid_o    (head_valid),
    .head_pc_o       (head_pc),
    .head_fu_o       (head_fu),
    .head_op_o       (head_op),
    .head_rd_o       (head_rd),
    .head_result_o   (head_result),
    .head_csr_addr_o (head_csr_addr),
    .head_ex_valid_o (head_ex_valid),
    .head_ex_cause_o (head_ex_cause)
  );

  commit_stage u_commit_stage (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .halt_i          (halt_i),
    .head_valid_i    (head_valid),
    .head_pc_i       (head_pc),
    .head_fu_i       (head_fu),
    .head_op_i       (head_op),
    .head_rd_i       (head_rd),
    .head_result_i   (head_result),
    .head_csr_addr_i (head_csr_addr),
    .head_ex_valid_i (head_ex_valid),
    .head_ex_cause_i (head_ex_cause),
    .csr_rdata_i     (csr_rdata),
    .csr_exception_i (csr_exception),
    .st_ready_i      (st_ready),
    .no_st_pending_i (no_st_pending),
    .commit_ack_o    (commit_ack),
    .flush_o         (flush),
    .rf_we_o         (rf_we_o),
    .rf_waddr_o      (rf_waddr_o),
    .rf_wdata_o      (rf_wdata_o),
    .csr_op_o        (csr_op),
    .csr_addr_o      (csr_addr),
    .csr_wdata_o     (csr_wdata),
    .csr_commit_o    (csr_commit),
    .fflags_we_o     (fflags_we),
    .fflags_wdata_o  (fflags_wdata),
    .trap_we_o       (trap_we),
    .trap_pc_o       (trap_pc),
    .trap_cause_o    (trap_cause),
    .commit_st_o     (commit_st),
    .st_data_o       (commit_st_data),
    .fence_o         (fence_o),
    .exc_valid_o     (exc_valid_o),
    .exc_cause_o     (exc_cause_o),
    .exc_tval_o      (exc_tval_o)
  );

  csr_file u_csr_file (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .csr_op_i        (csr_op),
    .csr_addr_i      (csr_addr),
    .csr_wdata_i     (csr_wdata),
    .csr_commit_i    (csr_commit),
    .fflags_we_i     (fflags_we),
    .fflags_wdata_i  (fflags_wdata),
    .trap_we_i       (trap_we),
    .trap_pc_i       (trap_pc),
    .trap_cause_i    (trap_cause),
    .csr_rdata_o     (csr_rdata),
    .csr_exception_o (csr_exception)
  );

  store_commit_port u_store_commit_port (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .commit_st_i     (commit_st),
    .st_data_i       (commit_st_data),
    .st_ack_i        (st_ack_i),
    .st_ready_o      (st_ready),
    .no_st_pending_o (no_st_pending),
    .st_req_o        (st_req_o),
    .st_data_o       (st_data_o)
  );

endmodule

`default_nettype wire

// File: dv/tb_retire_unit.sv
/* table-driven testbench for the retire unit with a memory-side store responder
   using LFSR delays, retire event monitors and a value check task */
`timescale 1ns/1ps
`default_nettype none

module tb_retire_unit import retire_pkg::*; ();

  // expected event kinds and per-row halt control
  localparam int K_NONE    = 0;
  localparam int K_WR      = 1;
  localparam int K_ST      = 2;
  localparam int K_EXC     = 3;
  localparam int K_FENCE   = 4;
  localparam int C_NONE    = 0;
  localparam int C_HALT    = 1;
  localparam int C_RELEASE = 2;
  localparam int TIMEOUT   = 1000;

  typedef struct {
    logic [XLEN-1:0]       pc;
    fu_t                   fu;
    op_t                   op;
    logic [REG_ADDR_W-1:0] rd;
    logic [XLEN-1:0]       result;
    logic [CSR_ADDR_W-1:0] csr_addr;
    logic                  ex_valid;
    logic [CAUSE_W-1:0]    ex_cause;
    int                    kind;
    // write rd or exception cause
    logic [XLEN-1:0]       exp_a;
    // write data, store data or tval
    logic [XLEN-1:0]       exp_b;
    int                    ctl;
  } row_t;

  logic                  clk = 1'b0;
  logic                  rst_n;
  logic                  halt;
  logic                  in_req;
  logic [XLEN-1:0]       in_pc;
  fu_t                   in_fu;
  op_t                   in_op;
  logic [REG_ADDR_W-1:0] in_rd;
  logic [XLEN-1:0]       in_result;
  logic [CSR_ADDR_W-1:0] in_csr_addr;
  logic                  in_ex_valid;
  logic [CAUSE_W-1:0]    in_ex_cause;
  logic                  st_ack = 1'b0;
  logic                  in_ack;
  logic                  rf_we;
  logic [REG_ADDR_W-1:0] rf_waddr;
  logic [XLEN-1:0]       rf_wdata;
  logic                  fence;
  logic                  exc_valid;
  logic [CAUSE_W-1:0]    exc_cause;
  logic [XLEN-1:0]       exc_tval;
  logic                  st_req;
  logic [XLEN-1:0]       st_data;

  row_t                  rows [$];
  // expected events in retire order per kind
  logic [REG_ADDR_W-1:0] wr_rd_q [$];
  logic [XLEN-1:0]       wr_data_q [$];
  logic [XLEN-1:0]       st_data_q [$];
  logic [CAUSE_W-1:0]    exc_cause_q [$];
  logic [XLEN-1:0]       exc_tval_q [$];
  int                    fences_left = 0;
  int                    st_seen = 0;
  int                    st_done = 0;
  logic                  st_req_prev = 1'b0;
  logic [15:0]           lfsr_q = 16'd14325;
  logic [3:0]            delay_left;

  retire_unit DUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .halt_i        (halt),
    .in_req_i      (in_req),
    .in_pc_i       (in_pc),
    .in_fu_i       (in_fu),
    .in_op_i       (in_op),
    .in_rd_i       (in_rd),
    .in_result_i   (in_result),
    .in_csr_addr_i (in_csr_addr),
    .in_ex_valid_i (in_ex_valid),
    .in_ex_cause_i (in_ex_cause),
    .st_ack_i      (st_ack),
    .in_ack_o      (in_ack),
    .rf_we_o       (rf_we),
    .rf_waddr_o    (rf_waddr),
    .rf_wdata_o    (rf_wdata),
    .fence_o       (fence),
    .exc_valid_o   (exc_valid),
    .exc_cause_o   (exc_cause),
    .exc_tval_o    (exc_tval),
    .st_req_o      (st_req),
    .st_data_o     (st_data)
  );

  // 100 ns clock
  always #50 clk = ~clk;

  // --------------------
  // helpers
  // --------------------
  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string msg);
    if (actual !== expected) begin
      $display("[FAIL] %0t: %s (got 0x%08h, expected 0x%08h)", $time, msg, actual, expected);
      $display("Simulation failed");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic abort_run(input string reason);
    $display("error at %0t: %s", $time, reason);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // taps x^16 + x^14 + x^13 + x^11 + 1 and one step per bit
  function automatic logic lfsr_step();
    logic fb;
    fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
    lfsr_q = {lfsr_q[14:0], fb};
    return fb;
  endfunction

  function automatic logic [3:0] random_delay();
    logic [3:0] d;
    d = '0;
    for (int b = 0; b < 4; b++) begin
      d[b] = lfsr_step();
    end
    return d;
  endfunction

  function automatic void add_row(input logic [31:0] pc, input fu_t fu, input op_t op,
                                  input logic [31:0] rd, input logic [31:0] result,
                                  input logic [31:0] csr, input logic [31:0] exv,
                                  input logic [31:0] cause, input int kind,
                                  input logic [31:0] exp_a, input logic [31:0] exp_b,
                                  input int ctl);
    row_t r;
    r.pc       = pc;
    r.fu       = fu;
    r.op       = op;
    r.rd       = rd[REG_ADDR_W-1:0];
    r.result   = result;
    r.csr_addr = csr[CSR_ADDR_W-1:0];
    r.ex_valid = exv[0];
    r.ex_cause = cause[CAUSE_W-1:0];
    r.kind     = kind;
    r.exp_a    = exp_a;
    r.exp_b    = exp_b;
    r.ctl      = ctl;
    rows.push_back(r);
  endfunction

  // --------------------
  // stimulus table
  // --------------------
  // pc, fu, op, rd, result, csr, ex_valid, ex_cause, kind, exp_a, exp_b, ctl
  function automatic void build_table();
    // plain writes where rd 0 is dropped
    add_row('h0100, FU_ALU,   OP_NONE,  1,  'h1111_1111, 'h000, 0, 0, K_WR, 1,  'h1111_1111, C_NONE);
    add_row('h0104, FU_LOAD,  OP_NONE,  2,  'h2222_2222, 'h000, 0, 0, K_WR, 2,  'h2222_2222, C_NONE);
    add_row('h0108, FU_ALU,   OP_NONE,  0,  'hDEAD_BEEF, 'h000, 0, 0, K_NONE, 0, 0, C_NONE);
    add_row('h010C, FU_FPU,   OP_NONE,  3,  'h3F80_0000, 'h000, 0, 1, K_WR, 3,  'h3F80_0000, C_NONE);
    // stores under random ack delays with an rd that stays unwritten
    add_row('h0110, FU_STORE, OP_NONE,  16, 'hA5A5_0001, 'h000, 0, 0, K_ST, 0,  'hA5A5_0001, C_NONE);
    add_row('h0114, FU_STORE, OP_NONE,  17, 'hA5A5_0002, 'h000, 0, 0, K_ST, 0,  'hA5A5_0002, C_NONE);
    add_row('h0118, FU_ALU,   OP_NONE,  4,  'h4444_4444, 'h000, 0, 0, K_WR, 4,  'h4444_4444, C_NONE);
    add_row('h011C, FU_STORE, OP_NONE,  18, 'hA5A5_0003, 'h000, 0, 0, K_ST, 0,  'hA5A5_0003, C_NONE);
    // fence right behind a store
    add_row('h0120, FU_FENCE, OP_FENCE, 0,  'h0,         'h000, 0, 0, K_FENCE, 0, 0, C_NONE);
    // csr swaps and then fflags accrued from 'h01 and 'h04
    add_row('h0124, FU_CSR,   OP_CSRRW, 8,  'h1234_5678, 'h340, 0, 0, K_WR, 8,  'h0,         C_NONE);
    add_row('h0128, FU_CSR,   OP_CSRRW, 9,  'hCAFE_F00D, 'h340, 0, 0, K_WR, 9,  'h1234_5678, C_NONE);
    add_row('h012C, FU_FPU,   OP_NONE,  10, 'h4000_0000, 'h000, 0, 4, K_WR, 10, 'h4000_0000, C_NONE);
    add_row('h0130, FU_CSR,   OP_CSRRS, 11, 'h0,         'h001, 0, 0, K_WR, 11, 'h5,         C_NONE);
    // queued under halt so the exception flushes the two rows behind it
    add_row('h0200, FU_ALU,   OP_NONE,  5,  'h5555_5555, 'h000, 1, 5, K_EXC, 5, 'h0200,      C_HALT);
    add_row('h0204, FU_ALU,   OP_NONE,  12, 'h6666_6666, 'h000, 0, 0, K_NONE, 0, 0, C_NONE);
    add_row('h0208, FU_ALU,   OP_NONE,  13, 'h7777_7777, 'h000, 0, 0, K_NONE, 0, 0, C_RELEASE);
    // unknown csr address and then mepc holds its pc
    add_row('h020C, FU_CSR,   OP_CSRRS, 6,  'h0,         'h7C0, 0, 0, K_EXC, 2, 'h020C,      C_NONE);
    add_row('h0210, FU_CSR,   OP_CSRRS, 7,  'h0,         'h341, 0, 0, K_WR, 7,  'h020C,      C_NONE);
    // nothing retires until halt falls
    add_row('h0300, FU_ALU,   OP_NONE,  14, 'h8888_8888, 'h000, 0, 0, K_WR, 14, 'h8888_8888, C_HALT);
    add_row('h0304, FU_STORE, OP_NONE,  19, 'hA5A5_0004, 'h000, 0, 0, K_ST, 0,  'hA5A5_0004, C_NONE);
    add_row('h0308, FU_ALU,   OP_NONE,  15, 'h9999_9999, 'h000, 0, 0, K_WR, 15, 'h9999_9999, C_RELEASE);
  endfunction

  // --------------------
  // intake driver
  // --------------------
  task automatic feed_row(input int idx);
    row_t r;
    int   cycles;
    r = rows[idx];
    // expectation goes in before the row can possibly retire
    case (r.kind)
      K_WR: begin
        wr_rd_q.push_back(r.exp_a[REG_ADDR_W-1:0]);
        wr_data_q.push_back(r.exp_b);
      end
      K_ST: st_data_q.push_back(r.exp_b);
      K_EXC: begin
        exc_cause_q.push_back(r.exp_a[CAUSE_W-1:0]);
        exc_tval_q.push_back(r.exp_b);
      end
      K_FENCE: fences_left++;
      default: ;
    endcase
    @(posedge clk);
    in_pc       <= r.pc;
    in_fu       <= r.fu;
    in_op       <= r.op;
    in_rd       <= r.rd;
    in_result   <= r.result;
    in_csr_addr <= r.csr_addr;
    in_ex_valid <= r.ex_valid;
    in_ex_cause <= r.ex_cause;
    in_req      <= 1'b1;
    cycles = 0;
    @(negedge clk);
    while (!in_ack) begin
      cycles++;
      if (cycles > TIMEOUT) abort_run("in_ack_o never rose for a queued row");
      @(negedge clk);
    end
    @(posedge clk);
    in_req <= 1'b0;
    cycles = 0;
    @(negedge clk);
    while (in_ack) begin
      cycles++;
      if (cycles > TIMEOUT) abort_run("in_ack_o stayed high after in_req_i fell");
      @(negedge clk);
    end
  endtask

  // wait until every expected event was seen and the store port is quiet
  task automatic drain_pipeline();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (wr_rd_q.size() != 0 || st_data_q.size() != 0 || exc_cause_q.size() != 0 ||
           fences_left != 0 || st_req || st_ack) begin
      cycles++;
      if (cycles > TIMEOUT) abort_run("expected retire events never appeared");
      @(negedge clk);
    end
  endtask

  // --------------------
  // memory responder
  // --------------------
  always @(posedge clk) begin
    if (!rst_n) begin
      st_ack     <= 1'b0;
      delay_left <= 4'd3;
    end else if (st_req && !st_ack) begin
      if (delay_left == 4'd0) begin
        st_ack <= 1'b1;
      end else begin
        delay_left <= delay_left - 4'd1;
      end
    end else if (!st_req && st_ack) begin
      // release seen so the handshake is complete
      st_ack     <= 1'b0;
      st_done    <= st_done + 1;
      delay_left <= random_delay();
    end
  end

  // --------------------
  // retire monitors
  // --------------------
  always @(negedge clk) begin
    if (rst_n) begin
      if (halt) begin
        check_value(32'(rf_we || exc_valid || fence || (st_req && !st_req_prev)), 32'd0,
                    "retire activity while halt_i is high");
      end
      if (rf_we) begin
        if (wr_rd_q.size() == 0) begin
          abort_run("register write appeared with no write expected");
        end else begin
          check_value(32'(rf_waddr), 32'(wr_rd_q[0]), "register write address");
          check_value(rf_wdata, wr_data_q[0], "register write data");
          void'(wr_rd_q.pop_front());
          void'(wr_data_q.pop_front());
        end
      end
      if (st_req && !st_req_prev) begin
        st_seen++;
        if (st_data_q.size() == 0) begin
          abort_run("store request appeared with no store expected");
        end else begin
          check_value(st_data, st_data_q[0], "store data");
          void'(st_data_q.pop_front());
        end
      end
      if (exc_valid) begin
        check_value(32'(rf_we), 32'd0, "register write alongside an exception");
        if (exc_cause_q.size() == 0) begin
          abort_run("exception reported with none expected");
        end else begin
          check_value(32'(exc_cause), 32'(exc_cause_q[0]), "exception cause");
          check_value(exc_tval, exc_tval_q[0], "exception tval");
          void'(exc_cause_q.pop_front());
          void'(exc_tval_q.pop_front());
        end
      end
      if (fence) begin
        // every store handshake must be finished before the fence retires
        check_value(32'(fences_left > 0), 32'd1, "fence_o pulse expected");
        check_value(32'(st_done), 32'(st_seen), "completed store handshakes at fence");
        fences_left--;
      end
    end
    st_req_prev = st_req;
  end

  // --------------------
  // main sequence
  // --------------------
  initial begin
    rst_n       <= 1'b0;
    halt        <= 1'b0;
    in_req      <= 1'b0;
    in_pc       <= '0;
    in_fu       <= FU_ALU;
    in_op       <= OP_NONE;
    in_rd       <= '0;
    in_result   <= '0;
    in_csr_addr <= '0;
    in_ex_valid <= 1'b0;
    in_ex_cause <= '0;
    build_table();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    for (int i = 0; i < rows.size(); i++) begin
      if (rows[i].ctl == C_HALT) begin
        drain_pipeline();
        @(posedge clk);
        halt <= 1'b1;
      end
      feed_row(i);
      if (rows[i].ctl == C_RELEASE) begin
        @(posedge clk);
        halt <= 1'b0;
      end
    end
    drain_pipeline();
    check_value(32'(st_done), 32'(st_seen), "store handshakes left open at the end");
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

// File: retire_unit.f
verilog/retire_pkg.sv
verilog/instr_queue.sv
verilog/commit_stage.sv
verilog/csr_file.sv
verilog/store_commit_port.sv
verilog/retire_unit.sv
dv/tb_retire_unit.sv

// File: Makefile
# Verilator flow for the retire unit
VERILATOR ?= verilator
TB_TOP    ?= tb_retire_unit
RTL_TOP   ?= retire_unit
FILELIST  ?= retire_unit.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Simulation completed successfully
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only -Wall --timing --top-module $(RTL_TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
